// ==== hdl/reg_valid_pkg.sv ====
// Register scoreboard shared types
`default_nettype none

package reg_valid_pkg;

	// ==============================
	// reorder tags
	// ==============================

	// width of a reorder buffer tag carried by queue slots and commit buses
	localparam int TAG_W = 4;

	// the tag of the in-flight instruction a register waits on
	typedef logic [TAG_W-1:0] tag_t;

	// ==============================
	// default sizes
	// ==============================

	// eight architectural registers, the last one being the status register
	localparam int AREGS_DEFAULT = 8;

	// queue slots that may claim a destination in one cycle
	localparam int QSLOTS_DEFAULT = 3;

	// commit buses that may release a destination in one cycle
	localparam int COMMITS_DEFAULT = 3;

endpackage

`default_nettype wire

// ==== hdl/claim_commit_decode.sv ====
// Claim and commit request decoder
`timescale 1ns/1ps
`default_nettype none

module claim_commit_decode #(
	parameter int AREGS   = reg_valid_pkg::AREGS_DEFAULT,
	parameter int QSLOTS  = reg_valid_pkg::QSLOTS_DEFAULT,
	parameter int COMMITS = reg_valid_pkg::COMMITS_DEFAULT
) (
	// queue side, one entry per slot
	input  wire logic [QSLOTS-1:0]                      slot_v,
	input  wire logic [QSLOTS-1:0]                      slot_rfw,
	input  wire logic [QSLOTS-1:0]                      slot_sr_wr,
	input  wire logic [QSLOTS-1:0][$clog2(AREGS)-1:0]   slot_rd,
	input  wire reg_valid_pkg::tag_t [QSLOTS-1:0]       slot_tag,
	// commit side, one entry per bus
	input  wire logic [COMMITS-1:0]                     commit_v,
	input  wire logic [COMMITS-1:0]                     commit_rfw,
	input  wire logic [COMMITS-1:0]                     commit_sr_wr,
	input  wire logic [COMMITS-1:0][$clog2(AREGS)-1:0]  commit_rd,
	input  wire reg_valid_pkg::tag_t [COMMITS-1:0]      commit_tag,
	// branch recovery
	input  wire logic                                   branch_miss,
	input  wire logic [AREGS-1:0]                       live_mask,
	// per-register request lines
	output logic [AREGS-1:0]                            claim,
	output reg_valid_pkg::tag_t [AREGS-1:0]             claim_tag,
	output logic [AREGS-1:0]                            release_req,
	output reg_valid_pkg::tag_t [AREGS-1:0]             release_tag,
	output logic [AREGS-1:0]                            force_valid
);

	localparam int RW = $clog2(AREGS);

	for (genvar r = 0; r < AREGS; r++) begin : g_reg
		// index of this register as it appears on rd fields
		localparam logic [RW-1:0] RIDX = RW'(r);
		// the top register doubles as the status register
		localparam bit IS_SR = (r == AREGS - 1);

		logic                claim_hit;
		reg_valid_pkg::tag_t claim_sel;
		logic                release_hit;
		reg_valid_pkg::tag_t release_sel;

		// ==============================
		// slot claims
		// ==============================

		// slots are scanned from low to high so the highest hitting slot
		// leaves its tag behind, which matches program order within a group
		always_comb begin
			claim_hit = 1'b0;
			claim_sel = '0;
			for (int s = 0; s < QSLOTS; s++) begin
				if (slot_v[s] && ((slot_rfw[s] && slot_rd[s] == RIDX) ||
						(slot_sr_wr[s] && IS_SR))) begin
					claim_hit = 1'b1;
					claim_sel = slot_tag[s];
				end
			end
		end

		// ==============================
		// commit releases
		// ==============================

		// same scan order for commits, the highest bus supplies the tag
		always_comb begin
			release_hit = 1'b0;
			release_sel = '0;
			for (int c = 0; c < COMMITS; c++) begin
				if (commit_v[c] && ((commit_rfw[c] && commit_rd[c] == RIDX) ||
						(commit_sr_wr[c] && IS_SR))) begin
					release_hit = 1'b1;
					release_sel = commit_tag[c];
				end
			end
		end

		// a branch miss squashes everything queued in the same cycle
		assign claim[r]       = claim_hit && !branch_miss;
		assign claim_tag[r]   = claim_sel;
		assign release_req[r] = release_hit;
		assign release_tag[r] = release_sel;
		// registers not written by surviving instructions become valid again
		assign force_valid[r] = branch_miss && !live_mask[r];
	end

endmodule

`default_nettype wire

// ==== hdl/reg_valid_cell.sv ====
// Register valid cell
`timescale 1ns/1ps
`default_nettype none

module reg_valid_cell (
	input  wire logic                clk,
	input  wire logic                rst,
	// a queue slot takes this register as its destination
	input  wire logic                claim,
	input  wire reg_valid_pkg::tag_t claim_tag,
	// a commit bus writes this register back
	input  wire logic                release_req,
	input  wire reg_valid_pkg::tag_t release_tag,
	// branch recovery makes the register valid unconditionally
	input  wire logic                force_valid,
	output logic                     valid,
	output logic                     valid_next,
	output reg_valid_pkg::tag_t      src_tag
);

	logic tag_match;

	// ==============================
	// release check
	// ==============================

	// the register may have been claimed again after the committing
	// instruction was queued, so only the latest claimant can release it
	assign tag_match = release_req && !valid && (release_tag == src_tag);

	// advanced valid for read-through operand access
	// a claim this cycle does not pull it low, the claimant reads
	// its sources before its own destination is marked busy
	assign valid_next = valid || force_valid || tag_match;

	// ==============================
	// state
	// ==============================

	always_ff @(posedge clk) begin
		if (rst) begin
			valid   <= 1'b1;
			src_tag <= '0;
		end else if (claim) begin
			// a fresh claim beats a release or forced valid in the same cycle
			valid   <= 1'b0;
			src_tag <= claim_tag;
		end else begin
			valid <= valid_next;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/operand_ready_lookup.sv ====
// Source operand ready lookup
`timescale 1ns/1ps
`default_nettype none

module operand_ready_lookup #(
	parameter int AREGS  = reg_valid_pkg::AREGS_DEFAULT,
	parameter int QSLOTS = reg_valid_pkg::QSLOTS_DEFAULT
) (
	// source register named by each slot
	input  wire logic [QSLOTS-1:0][$clog2(AREGS)-1:0] rs_idx,
	// advanced valid and waiting tag of every register
	input  wire logic [AREGS-1:0]                     reg_is_valid,
	input  wire reg_valid_pkg::tag_t [AREGS-1:0]      src_tag,
	output logic [QSLOTS-1:0]                         rs_ready,
	output reg_valid_pkg::tag_t [QSLOTS-1:0]          rs_tag
);

	// ==============================
	// per-slot select
	// ==============================

	for (genvar s = 0; s < QSLOTS; s++) begin : g_slot
		logic in_range;

		// with a register count that is not a power of two some indices
		// name no register, those read as an always-ready constant
		assign in_range = (int'(rs_idx[s]) < AREGS);

		always_comb begin
			if (in_range) begin
				rs_ready[s] = reg_is_valid[rs_idx[s]];
				rs_tag[s]   = src_tag[rs_idx[s]];
			end else begin
				rs_ready[s] = 1'b1;
				rs_tag[s]   = '0;
			end
		end
	end

	// a consumer that sees ready low waits for a commit carrying rs_tag

endmodule

`default_nettype wire

// ==== hdl/reg_valid_scoreboard.sv ====
// Register valid scoreboard top
`timescale 1ns/1ps
`default_nettype none

module reg_valid_scoreboard #(
	parameter int AREGS   = reg_valid_pkg::AREGS_DEFAULT,
	parameter int QSLOTS  = reg_valid_pkg::QSLOTS_DEFAULT,
	parameter int COMMITS = reg_valid_pkg::COMMITS_DEFAULT
) (
	input  wire logic                                   clk,
	input  wire logic                                   rst,
	// queue side
	input  wire logic [QSLOTS-1:0]                      slot_v,
	input  wire logic [QSLOTS-1:0]                      slot_rfw,
	input  wire logic [QSLOTS-1:0]                      slot_sr_wr,
	input  wire logic [QSLOTS-1:0][$clog2(AREGS)-1:0]   slot_rd,
	input  wire reg_valid_pkg::tag_t [QSLOTS-1:0]       slot_tag,
	// commit side
	input  wire logic [COMMITS-1:0]                     commit_v,
	input  wire logic [COMMITS-1:0]                     commit_rfw,
	input  wire logic [COMMITS-1:0]                     commit_sr_wr,
	input  wire logic [COMMITS-1:0][$clog2(AREGS)-1:0]  commit_rd,
	input  wire reg_valid_pkg::tag_t [COMMITS-1:0]      commit_tag,
	// branch recovery
	input  wire logic                                   branch_miss,
	input  wire logic [AREGS-1:0]                       live_mask,
	// operand lookups
	input  wire logic [QSLOTS-1:0][$clog2(AREGS)-1:0]   rs_idx,
	output logic [AREGS-1:0]                            rf_v,
	output logic [AREGS-1:0]                            reg_is_valid,
	output logic [QSLOTS-1:0]                           rs_ready,
	output reg_valid_pkg::tag_t [QSLOTS-1:0]            rs_tag
);

	// ==============================
	// request decode
	// ==============================

	logic [AREGS-1:0]                claim;
	reg_valid_pkg::tag_t [AREGS-1:0] claim_tag;
	logic [AREGS-1:0]                release_req;
	reg_valid_pkg::tag_t [AREGS-1:0] release_tag;
	logic [AREGS-1:0]                force_valid;
	reg_valid_pkg::tag_t [AREGS-1:0] src_tag;

	claim_commit_decode #(
		.AREGS  (AREGS),
		.QSLOTS (QSLOTS),
		.COMMITS(COMMITS)
	) decode_i (
		.slot_v      (slot_v),
		.slot_rfw    (slot_rfw),
		.slot_sr_wr  (slot_sr_wr),
		.slot_rd     (slot_rd),
		.slot_tag    (slot_tag),
		.commit_v    (commit_v),
		.commit_rfw  (commit_rfw),
		.commit_sr_wr(commit_sr_wr),
		.commit_rd   (commit_rd),
		.commit_tag  (commit_tag),
		.branch_miss (branch_miss),
		.live_mask   (live_mask),
		.claim       (claim),
		.claim_tag   (claim_tag),
		.release_req (release_req),
		.release_tag (release_tag),
		.force_valid (force_valid)
	);

	// ==============================
	// one cell per register
	// ==============================

	for (genvar r = 0; r < AREGS; r++) begin : g_cell
		reg_valid_cell cell_i (
			.clk        (clk),
			.rst        (rst),
			.claim      (claim[r]),
			.claim_tag  (claim_tag[r]),
			.release_req(release_req[r]),
			.release_tag(release_tag[r]),
			.force_valid(force_valid[r]),
			.valid      (rf_v[r]),
			.valid_next (reg_is_valid[r]),
			.src_tag    (src_tag[r])
		);
	end

	// operand reads use the advanced vector so a same-cycle commit counts
	operand_ready_lookup #(
		.AREGS (AREGS),
		.QSLOTS(QSLOTS)
	) lookup_i (
		.rs_idx      (rs_idx),
		.reg_is_valid(reg_is_valid),
		.src_tag     (src_tag),
		.rs_ready    (rs_ready),
		.rs_tag      (rs_tag)
	);

endmodule

`default_nettype wire

// ==== test/reg_valid_scoreboard_sva.sv ====
// Scoreboard bound assertions
`timescale 1ns/1ps
`default_nettype none

module reg_valid_scoreboard_sva #(
	parameter int AREGS = reg_valid_pkg::AREGS_DEFAULT
) (
	input wire logic             clk,
	input wire logic             rst,
	input wire logic [AREGS-1:0] claim,
	input wire logic [AREGS-1:0] rf_v,
	input wire logic [AREGS-1:0] reg_is_valid
);

	// ==============================
	// reset and claim rules
	// ==============================

	// every register comes out of reset valid
	a_reset_valid: assert property (@(posedge clk) rst |=> (rf_v == '1))
		else $error("rf_v not all ones after reset");

	// the decoder already drops claims during a branch miss,
	// so any claim seen here must clear its register at the next edge
	a_claim_clears: assert property (@(posedge clk) disable iff (rst)
		(claim != '0) |=> ((rf_v & $past(claim)) == '0))
		else $error("claimed register still valid after the edge");

	// the advanced vector announces the registered vector of the next edge,
	// apart from registers that a claim takes in the same cycle
	a_advance: assert property (@(posedge clk) disable iff (rst)
		1'b1 |=> (rf_v == ($past(reg_is_valid) & ~$past(claim))))
		else $error("rf_v differs from the advanced vector of the cycle before");

endmodule

bind reg_valid_scoreboard reg_valid_scoreboard_sva #(
	.AREGS(AREGS)
) sva_i (
	.clk         (clk),
	.rst         (rst),
	.claim       (claim),
	.rf_v        (rf_v),
	.reg_is_valid(reg_is_valid)
);

`default_nettype wire

// ==== test/reg_valid_scoreboard_tb.sv ====
// Register valid scoreboard testbench
`timescale 1ns/1ps
`default_nettype none

module reg_valid_scoreboard_tb;

	localparam int AREGS   = reg_valid_pkg::AREGS_DEFAULT;
	localparam int QSLOTS  = reg_valid_pkg::QSLOTS_DEFAULT;
	localparam int COMMITS = reg_valid_pkg::COMMITS_DEFAULT;
	localparam int RW      = $clog2(AREGS);
	localparam int TW      = reg_valid_pkg::TAG_W;
	// fields per golden line, inputs first and expected values last
	localparam int NFIELDS = 29;
	localparam int MAX_CYCLES = 500;

	logic                                  clk;
	logic                                  rst;
	logic [QSLOTS-1:0]                     slot_v;
	logic [QSLOTS-1:0]                     slot_rfw;
	logic [QSLOTS-1:0]                     slot_sr_wr;
	logic [QSLOTS-1:0][RW-1:0]             slot_rd;
	reg_valid_pkg::tag_t [QSLOTS-1:0]      slot_tag;
	logic [COMMITS-1:0]                    commit_v;
	logic [COMMITS-1:0]                    commit_rfw;
	logic [COMMITS-1:0]                    commit_sr_wr;
	logic [COMMITS-1:0][RW-1:0]            commit_rd;
	reg_valid_pkg::tag_t [COMMITS-1:0]     commit_tag;
	logic                                  branch_miss;
	logic [AREGS-1:0]                      live_mask;
	logic [QSLOTS-1:0][RW-1:0]             rs_idx;
	logic [AREGS-1:0]                      rf_v;
	logic [AREGS-1:0]                      reg_is_valid;
	logic [QSLOTS-1:0]                     rs_ready;
	reg_valid_pkg::tag_t [QSLOTS-1:0]      rs_tag;

	reg_valid_scoreboard #(
		.AREGS  (AREGS),
		.QSLOTS (QSLOTS),
		.COMMITS(COMMITS)
	) dut_i (
		.clk         (clk),
		.rst         (rst),
		.slot_v      (slot_v),
		.slot_rfw    (slot_rfw),
		.slot_sr_wr  (slot_sr_wr),
		.slot_rd     (slot_rd),
		.slot_tag    (slot_tag),
		.commit_v    (commit_v),
		.commit_rfw  (commit_rfw),
		.commit_sr_wr(commit_sr_wr),
		.commit_rd   (commit_rd),
		.commit_tag  (commit_tag),
		.branch_miss (branch_miss),
		.live_mask   (live_mask),
		.rs_idx      (rs_idx),
		.rf_v        (rf_v),
		.reg_is_valid(reg_is_valid),
		.rs_ready    (rs_ready),
		.rs_tag      (rs_tag)
	);

	// 10 ns clock
	always #5 clk = ~clk;

	// ==============================
	// compare tasks
	// ==============================

	// register and slot bit vectors, slot vectors are zero extended
	task automatic check_mask(input string name, input logic [AREGS-1:0] got,
			input logic [AREGS-1:0] exp);
		if (got !== exp) begin
			$display("** Error: %s got %h expected %h", name, got, exp);
			$display("Verification failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	task automatic check_tag(input string name, input reg_valid_pkg::tag_t got,
			input reg_valid_pkg::tag_t exp);
		if (got !== exp) begin
			$display("** Error: %s got %h expected %h", name, got, exp);
			$display("Verification failed");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// any failure that is not a value mismatch
	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1, "run aborted");
	endtask

	// all inputs idle
	task automatic clear_inputs();
		slot_v       = '0;
		slot_rfw     = '0;
		slot_sr_wr   = '0;
		slot_rd      = '0;
		slot_tag     = '0;
		commit_v     = '0;
		commit_rfw   = '0;
		commit_sr_wr = '0;
		commit_rd    = '0;
		commit_tag   = '0;
		branch_miss  = 1'b0;
		live_mask    = '0;
		rs_idx       = '0;
	endtask

	// ==============================
	// main sequence
	// ==============================

	initial begin
		int          fd;
		int          n;
		int          cycles;
		int          i;
		int          k;
		int          start;
		string       line;
		string       tok;
		logic [31:0] fld [NFIELDS];

		cycles      = 0;
		clk         = 1'b0;
		rst         = 1'b1;
		clear_inputs();

		// hold reset over two rising edges
		for (i = 0; i < 2; i++) begin
			@(posedge clk);
		end
		#1 rst = 1'b0;

		// the valid vector must settle to all ones shortly after reset
		i = 0;
		while (rf_v !== '1) begin
			if (i > 20) begin
				abort_run("timeout waiting for all registers valid after reset");
			end
			@(posedge clk);
			i++;
		end

		fd = $fopen("test/reg_valid_golden.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open the golden file");
		end

		while (!$feof(fd)) begin
			if (cycles > MAX_CYCLES) begin
				abort_run("timeout before the end of the golden file");
			end
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line[0] == "#") begin
				continue;
			end

			// split the line on blanks and read every field as hex
			n     = 0;
			start = -1;
			for (k = 0; k <= line.len(); k++) begin
				if (k == line.len() || line[k] == " " || line[k] == "\t" ||
						line[k] == "\n" || line[k] == "\r") begin
					if (start >= 0) begin
						if (n < NFIELDS) begin
							tok    = line.substr(start, k - 1);
							fld[n] = tok.atohex();
						end
						n++;
						start = -1;
					end
				end else if (start < 0) begin
					start = k;
				end
			end
			if (n != NFIELDS) begin
				abort_run("golden file line has the wrong number of fields");
			end

			// drive a little after the edge so the DUT sees stable inputs
			@(posedge clk);
			#1;
			slot_v     = fld[0][QSLOTS-1:0];
			slot_rfw   = fld[1][QSLOTS-1:0];
			slot_sr_wr = fld[2][QSLOTS-1:0];
			for (i = 0; i < QSLOTS; i++) begin
				slot_rd[i]  = fld[3 + i][RW-1:0];
				slot_tag[i] = fld[6 + i][TW-1:0];
			end
			commit_v     = fld[9][COMMITS-1:0];
			commit_rfw   = fld[10][COMMITS-1:0];
			commit_sr_wr = fld[11][COMMITS-1:0];
			for (i = 0; i < COMMITS; i++) begin
				commit_rd[i]  = fld[12 + i][RW-1:0];
				commit_tag[i] = fld[15 + i][TW-1:0];
			end
			branch_miss = fld[18][0];
			live_mask   = fld[19][AREGS-1:0];
			for (i = 0; i < QSLOTS; i++) begin
				rs_idx[i] = fld[20 + i][RW-1:0];
			end

			// combinational outputs are settled well before the next edge
			#4;
			check_mask("rf_v", rf_v, fld[23][AREGS-1:0]);
			check_mask("reg_is_valid", reg_is_valid, fld[24][AREGS-1:0]);
			check_mask("rs_ready", AREGS'(rs_ready), fld[25][AREGS-1:0]);
			for (i = 0; i < QSLOTS; i++) begin
				check_tag($sformatf("rs_tag[%0d]", i), rs_tag[i], fld[26 + i][TW-1:0]);
			end
			cycles++;
		end
		$fclose(fd);

		@(posedge clk);
		#1 clear_inputs();
		if (cycles > 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
hdl/reg_valid_pkg.sv
hdl/claim_commit_decode.sv
hdl/reg_valid_cell.sv
hdl/operand_ready_lookup.sv
hdl/reg_valid_scoreboard.sv
test/reg_valid_scoreboard_sva.sv
test/reg_valid_scoreboard_tb.sv

// ==== Makefile ====
# Verilator build and run for the register valid scoreboard

VERILATOR ?= verilator
TOP       ?= reg_valid_scoreboard_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST)) test/reg_valid_golden.txt
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "Verification passed" $(LOG); then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/reg_valid_golden.txt ====
# one cycle per line, all hex: sv rfw sr rd0 rd1 rd2 t0 t1 t2 | cv crfw csr crd0 crd1 crd2 ct0 ct1 ct2
# | branch_miss live_mask | rs0 rs1 rs2 | exp rf_v reg_is_valid rs_ready rs_tag0 rs_tag1 rs_tag2
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 0 3 7 ff ff 7 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 1 2 6 ff ff 7 0 0 0
1 1 0 3 0 0 5 0 0 0 0 0 0 0 0 0 0 0 0 00 3 0 0 ff ff 7 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 3 3 0 f7 f7 4 5 5 0
0 0 0 0 0 0 0 0 0 2 2 0 0 3 0 0 5 0 0 00 3 1 2 f7 ff 7 5 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 3 0 0 ff ff 7 5 0 0
2 2 0 0 2 0 0 a 0 0 0 0 0 0 0 0 0 0 0 00 2 2 2 ff ff 7 0 0 0
4 4 0 0 0 2 0 0 b 0 0 0 0 0 0 0 0 0 0 00 2 0 0 fb fb 6 a 0 0
0 0 0 0 0 0 0 0 0 1 1 0 2 0 0 a 0 0 0 00 2 0 0 fb fb 6 b 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 2 0 0 fb fb 6 b 0 0
0 0 0 0 0 0 0 0 0 4 4 0 0 0 2 0 0 b 0 00 2 0 0 fb ff 7 b 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 2 7 0 ff ff 7 b 0 0
7 6 1 0 5 5 3 6 7 0 0 0 0 0 0 0 0 0 0 00 7 5 0 ff ff 7 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 7 5 0 5f 5f 4 3 7 0
0 0 0 0 0 0 0 0 0 3 2 1 0 5 0 3 6 0 0 00 7 5 0 5f df 5 3 7 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 7 5 0 df df 5 3 7 0
1 1 0 1 0 0 9 0 0 0 0 0 0 0 0 0 0 0 0 00 1 5 0 df df 5 0 7 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 1 5 0 dd dd 4 9 7 0
1 1 0 4 0 0 c 0 0 0 0 0 0 0 0 0 0 0 1 02 1 5 4 dd fd 6 9 7 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 1 5 4 fd fd 6 9 7 0
0 0 0 0 0 0 0 0 0 2 2 0 0 1 0 0 9 0 0 00 1 0 0 fd ff 7 9 0 0
2 2 0 0 6 0 0 d 0 0 0 0 0 0 0 0 0 0 0 00 6 0 0 ff ff 7 0 0 0
1 1 0 6 0 0 e 0 0 1 1 0 6 0 0 d 0 0 0 00 6 6 6 bf ff 7 d d d
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 6 0 0 bf bf 6 e 0 0
0 0 0 0 0 0 0 0 0 4 4 0 0 0 6 0 0 e 0 00 6 0 0 bf ff 7 e 0 0
1 1 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 1 ff 0 0 0 ff ff 7 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 ff ff 7 0 0 0
4 4 0 0 0 0 0 0 4 0 0 0 0 0 0 0 0 0 0 00 0 0 0 ff ff 7 0 0 0
0 0 0 0 0 0 0 0 0 5 5 0 0 0 0 4 0 5 0 00 0 0 0 fe fe 0 4 4 4
0 0 0 0 0 0 0 0 0 3 3 0 0 0 0 5 4 0 0 00 0 0 0 fe ff 7 4 4 4
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 00 0 0 0 ff ff 7 4 4 4
